// File: design/desc_ram.sv
`timescale 1ns/1ps
`default_nettype none

module desc_ram (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   wr_en,
    input  wire sg_alloc_pkg::ptr_t  wr_ptr,
    input  wire sg_alloc_pkg::desc_t wr_desc,
    input  wire                   rd_en,
    input  wire sg_alloc_pkg::ptr_t  rd_ptr,
    output sg_alloc_pkg::desc_t   rd_desc
);

    import sg_alloc_pkg::*;

    // One descriptor per buffer pointer
    desc_t mem [NUM_BUFS];

    // ==============================
    // Write port
    // ==============================

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_desc;
        end
    end

    // ==============================
    // Read port
    // ==============================

    // Data appears the cycle after rd_en
    // and holds until the next read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_desc <= '0;
        end else if (rd_en) begin
            rd_desc <= mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

// File: design/free_list.sv
`timescale 1ns/1ps
`default_nettype none

module free_list (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 pop,
    input  wire                 push,
    input  wire sg_alloc_pkg::ptr_t push_ptr,
    output sg_alloc_pkg::ptr_t  head,
    output logic                empty,
    output logic                init_done
);

    import sg_alloc_pkg::*;

    // Pointer storage, one slot per buffer
    ptr_t               mem [NUM_BUFS];

    // Circular indices and occupancy
    ptr_t               rd_idx;
    ptr_t               wr_idx;
    logic [PTR_WID:0]   count;

    // Qualified requests
    logic               do_pop;
    logic               do_push;
    logic               mem_we;
    ptr_t               mem_wdata;

    // ==============================
    // Request qualification
    // ==============================

    // Nothing leaves the list until the fill is over
    assign empty   = !init_done || (count == '0);
    assign do_pop  = pop && !empty;
    assign do_push = push && init_done;

    // Fill phase writes the index value itself
    // so the list comes up as 0, 1, ... 15
    assign mem_we    = !init_done || do_push;
    assign mem_wdata = init_done ? push_ptr : wr_idx;

    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[wr_idx] <= mem_wdata;
        end
    end

    // Oldest free pointer
    assign head = mem[rd_idx];

    // ==============================
    // Indices, count, fill control
    // ==============================

    // Write index doubles as fill counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_idx    <= '0;
            wr_idx    <= '0;
            count     <= '0;
            init_done <= 1'b0;
        end else begin
            if (!init_done) begin
                wr_idx <= wr_idx + 1'b1;
                count  <= count + 1'b1;
                // Last slot written on this edge
                if (wr_idx == PTR_WID'(NUM_BUFS - 1)) begin
                    init_done <= 1'b1;
                end
            end else begin
                if (do_pop) begin
                    rd_idx <= rd_idx + 1'b1;
                end
                if (do_push) begin
                    wr_idx <= wr_idx + 1'b1;
                end
                // Simultaneous push and pop leaves count alone
                case ({do_push, do_pop})
                    2'b10:   count <= count + 1'b1;
                    2'b01:   count <= count - 1'b1;
                    default: count <= count;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: design/gather_port.sv
`timescale 1ns/1ps
`default_nettype none

module gather_port (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      gath_cyc,
    input  wire                      gath_stb,
    input  wire sg_alloc_pkg::ptr_t  gath_adr,
    input  wire sg_alloc_pkg::desc_t rd_desc,
    output logic                     gath_ack,
    output sg_alloc_pkg::desc_t      gath_dat,
    output logic                     rd_en,
    output sg_alloc_pkg::ptr_t       rd_ptr,
    output logic                     push,
    output sg_alloc_pkg::ptr_t       push_ptr
);

    import sg_alloc_pkg::*;

    gath_state_t state;

    // Address held for the read and the recycle
    ptr_t        adr_q;
    logic        start;

    assign start = (state == GATH_IDLE) && gath_cyc && gath_stb;

    // ==============================
    // FSM
    // ==============================

    // IDLE latches, READ hits the memory, ACK returns data
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= GATH_IDLE;
        end else begin
            case (state)
                GATH_IDLE: begin
                    if (start) begin
                        state <= GATH_READ;
                    end
                end
                GATH_READ: state <= GATH_ACK;
                GATH_ACK:  state <= GATH_IDLE;
                default:   state <= GATH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            adr_q <= gath_adr;
        end
    end

    // ==============================
    // Outputs
    // ==============================

    // Memory read one cycle ahead of the ack
    assign rd_en    = (state == GATH_READ);
    assign rd_ptr   = adr_q;

    assign gath_ack = (state == GATH_ACK);
    assign gath_dat = rd_desc;

    // Buffer goes back to the free list once its descriptor is out
    assign push     = gath_ack;
    assign push_ptr = adr_q;

endmodule

`default_nettype wire

// File: design/scatter_port.sv
`timescale 1ns/1ps
`default_nettype none

module scatter_port (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       scat_cyc,
    input  wire                       scat_stb,
    input  wire sg_alloc_pkg::store_t scat_dat,
    input  wire sg_alloc_pkg::ptr_t   head,
    input  wire                       empty,
    output logic                      scat_ack,
    output sg_alloc_pkg::ptr_t        scat_ptr,
    output logic                      pop,
    output logic                      wr_en,
    output sg_alloc_pkg::ptr_t        wr_ptr,
    output sg_alloc_pkg::desc_t       wr_desc,
    output sg_alloc_pkg::frame_rpt_t  frame
);

    import sg_alloc_pkg::*;

    scat_state_t                state;

    // Set once the head pointer of a frame is held
    logic                       frame_open;

    ptr_t                       cur_ptr;
    ptr_t                       next_ptr;
    ptr_t                       head_ptr;
    logic [FRAME_SIZE_WID-1:0]  size_acc;
    logic                       err_acc;

    logic                       take_cur;
    logic                       take_next;
    logic                       in_write;

    // ==============================
    // Pointer allocation
    // ==============================

    // First pointer of a frame is taken as soon as stb is seen
    // Link pointer taken in ALLOC, not needed for eof
    always_comb begin
        case (state)
            SCAT_IDLE:  pop = scat_cyc && scat_stb && !frame_open && !empty;
            SCAT_ALLOC: pop = !empty && (!frame_open || !scat_dat.eof);
            default:    pop = 1'b0;
        endcase
    end

    assign take_cur  = pop && !frame_open;
    assign take_next = pop && frame_open;
    assign in_write  = (state == SCAT_WRITE);

    // ==============================
    // FSM
    // ==============================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= SCAT_IDLE;
            frame_open <= 1'b0;
        end else begin
            case (state)
                SCAT_IDLE: begin
                    if (scat_cyc && scat_stb) begin
                        state <= SCAT_ALLOC;
                    end
                end
                SCAT_ALLOC: begin
                    // Wait here while the free list is short
                    if (frame_open && (scat_dat.eof || !empty)) begin
                        state <= SCAT_WRITE;
                    end
                end
                SCAT_WRITE: begin
                    state <= SCAT_IDLE;
                    if (scat_dat.eof) begin
                        frame_open <= 1'b0;
                    end
                end
                default: state <= SCAT_IDLE;
            endcase
            if (take_cur) begin
                frame_open <= 1'b1;
            end
        end
    end

    // Chain pointers and running totals
    always_ff @(posedge clk) begin
        if (take_cur) begin
            cur_ptr  <= head;
            head_ptr <= head;
            size_acc <= '0;
            err_acc  <= 1'b0;
        end else if (in_write && !scat_dat.eof) begin
            // Next buffer lands where this one points
            cur_ptr  <= next_ptr;
            size_acc <= size_acc + FRAME_SIZE_WID'(BUFFER_SIZE);
            err_acc  <= err_acc | scat_dat.err;
        end
        if (take_next) begin
            next_ptr <= head;
        end
    end

    // ==============================
    // Outputs
    // ==============================

    assign scat_ack = in_write;
    assign scat_ptr = cur_ptr;
    assign wr_en    = in_write;
    assign wr_ptr   = cur_ptr;

    always_comb begin
        wr_desc.next_ptr = next_ptr;
        wr_desc.eof      = scat_dat.eof;
        wr_desc.size     = scat_dat.size;
        wr_desc.meta     = scat_dat.meta;
        wr_desc.err      = scat_dat.err;

        // Report rides on the ack of the eof buffer
        frame.valid = in_write && scat_dat.eof;
        frame.ptr   = head_ptr;
        frame.size  = size_acc + FRAME_SIZE_WID'(scat_dat.size);
        frame.error = err_acc | scat_dat.err;
    end

endmodule

`default_nettype wire

// File: design/sg_alloc_pkg.sv
`default_nettype none

package sg_alloc_pkg;

    // ==============================
    // Sizes
    // ==============================

    // Pointer space, one pointer per buffer
    localparam int PTR_WID        = 4;
    localparam int NUM_BUFS       = 2 ** PTR_WID;

    // Bytes held by one buffer
    localparam int BUFFER_SIZE    = 64;
    localparam int SIZE_WID       = $clog2(BUFFER_SIZE);

    // Largest frame uses every buffer
    localparam int MAX_FRAME_SIZE = NUM_BUFS * BUFFER_SIZE;
    localparam int FRAME_SIZE_WID = $clog2(MAX_FRAME_SIZE + 1);

    // Opaque per-buffer metadata
    localparam int META_WID       = 4;

    // ==============================
    // Types
    // ==============================

    typedef logic [PTR_WID-1:0] ptr_t;

    // Scatter write data, size only valid with eof
    typedef struct packed {
        logic                eof;
        logic [SIZE_WID-1:0] size;
        logic [META_WID-1:0] meta;
        logic                err;
    } store_t;

    // Descriptor as kept in memory
    // next_ptr is don't-care on the last buffer
    typedef struct packed {
        ptr_t                next_ptr;
        logic                eof;
        logic [SIZE_WID-1:0] size;
        logic [META_WID-1:0] meta;
        logic                err;
    } desc_t;

    // One-cycle report at end of frame
    typedef struct packed {
        logic                      valid;
        ptr_t                      ptr;
        logic [FRAME_SIZE_WID-1:0] size;
        logic                      error;
    } frame_rpt_t;

    // ==============================
    // FSM states
    // ==============================

    typedef enum logic [1:0] {
        SCAT_IDLE,
        SCAT_ALLOC,
        SCAT_WRITE
    } scat_state_t;

    typedef enum logic [1:0] {
        GATH_IDLE,
        GATH_READ,
        GATH_ACK
    } gath_state_t;

endpackage

`default_nettype wire

// File: design/sg_alloc_top.sv
`timescale 1ns/1ps
`default_nettype none

module sg_alloc_top (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       scat_cyc,
    input  wire                       scat_stb,
    input  wire sg_alloc_pkg::store_t scat_dat,
    input  wire                       gath_cyc,
    input  wire                       gath_stb,
    input  wire sg_alloc_pkg::ptr_t   gath_adr,
    output logic                      init_done,
    output logic                      scat_ack,
    output sg_alloc_pkg::ptr_t        scat_ptr,
    output logic                      gath_ack,
    output sg_alloc_pkg::desc_t       gath_dat,
    output sg_alloc_pkg::frame_rpt_t  frame
);

    import sg_alloc_pkg::*;

    // Free list handshake
    logic  pop;
    logic  push;
    ptr_t  head;
    ptr_t  push_ptr;
    logic  empty;

    // Descriptor memory ports
    logic  wr_en;
    ptr_t  wr_ptr;
    desc_t wr_desc;
    logic  rd_en;
    ptr_t  rd_ptr;
    desc_t rd_desc;

    // Reads held off until the list is filled
    logic  gath_stb_ok;

    assign gath_stb_ok = gath_stb && init_done;

    // ==============================
    // Processing core
    // ==============================

    free_list u_free_list (
        .clk(clk), .rst_n(rst_n), .pop(pop), .push(push), .push_ptr(push_ptr),
        .head(head), .empty(empty), .init_done(init_done)
    );

    desc_ram u_desc_ram (
        .clk(clk), .rst_n(rst_n), .wr_en(wr_en), .wr_ptr(wr_ptr), .wr_desc(wr_desc),
        .rd_en(rd_en), .rd_ptr(rd_ptr), .rd_desc(rd_desc)
    );

    // ==============================
    // Bus ports
    // ==============================

    scatter_port u_scatter_port (
        .clk(clk), .rst_n(rst_n), .scat_cyc(scat_cyc), .scat_stb(scat_stb),
        .scat_dat(scat_dat), .head(head), .empty(empty), .scat_ack(scat_ack),
        .scat_ptr(scat_ptr), .pop(pop), .wr_en(wr_en), .wr_ptr(wr_ptr),
        .wr_desc(wr_desc), .frame(frame)
    );

    gather_port u_gather_port (
        .clk(clk), .rst_n(rst_n), .gath_cyc(gath_cyc), .gath_stb(gath_stb_ok),
        .gath_adr(gath_adr), .rd_desc(rd_desc), .gath_ack(gath_ack),
        .gath_dat(gath_dat), .rd_en(rd_en), .rd_ptr(rd_ptr), .push(push),
        .push_ptr(push_ptr)
    );

endmodule

`default_nettype wire

// File: list.f
design/sg_alloc_pkg.sv
design/free_list.sv
design/desc_ram.sv
design/scatter_port.sv
design/gather_port.sv
design/sg_alloc_top.sv
tests/sg_alloc_assert.sv
tests/sg_alloc_tb.sv

// File: tests/sg_alloc_assert.sv
`timescale 1ns/1ps
`default_nettype none

module sg_alloc_assert (
    input wire                             clk,
    input wire                             rst_n,
    input wire                             init_done,
    input wire                             scat_stb,
    input wire                             scat_ack,
    input wire                             gath_stb,
    input wire                             gath_ack,
    input wire sg_alloc_pkg::frame_rpt_t   frame
);

    // Failure tally, read by the testbench
    int assert_errors;

    initial assert_errors = 0;

    // ==============================
    // Handshake rules
    // ==============================

    // Acks are single-cycle pulses
    scat_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        scat_ack |=> !scat_ack)
        else begin
            $error("scat_ack held longer than one cycle");
            assert_errors++;
        end

    gath_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        gath_ack |=> !gath_ack)
        else begin
            $error("gath_ack held longer than one cycle");
            assert_errors++;
        end

    // Slave answers only a live strobe
    scat_ack_stb: assert property (@(posedge clk) disable iff (!rst_n)
        scat_ack |-> scat_stb)
        else begin
            $error("scat_ack without scat_stb");
            assert_errors++;
        end

    gath_ack_stb: assert property (@(posedge clk) disable iff (!rst_n)
        gath_ack |-> gath_stb)
        else begin
            $error("gath_ack without gath_stb");
            assert_errors++;
        end

    // Report rides on the eof ack
    frame_on_ack: assert property (@(posedge clk) disable iff (!rst_n)
        frame.valid |-> scat_ack)
        else begin
            $error("frame.valid without scat_ack");
            assert_errors++;
        end

    // Free list still filling
    quiet_before_init: assert property (@(posedge clk) disable iff (!rst_n)
        !init_done |-> !scat_ack && !gath_ack)
        else begin
            $error("ack before init_done");
            assert_errors++;
        end

endmodule

bind sg_alloc_top sg_alloc_assert u_sg_alloc_assert (
    .clk(clk), .rst_n(rst_n), .init_done(init_done), .scat_stb(scat_stb),
    .scat_ack(scat_ack), .gath_stb(gath_stb), .gath_ack(gath_ack), .frame(frame)
);

`default_nettype wire

// File: tests/sg_alloc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sg_alloc_tb;

    import sg_alloc_pkg::*;

    localparam int TIMEOUT_CYCLES = 4000;
    localparam int RESET_CYCLES   = 16;
    localparam int FILL_CYCLES    = 16;

    logic       clk;
    logic       rst_n;
    logic       scat_cyc;
    logic       scat_stb;
    store_t     scat_dat;
    logic       gath_cyc;
    logic       gath_stb;
    ptr_t       gath_adr;
    logic       init_done;
    logic       scat_ack;
    ptr_t       scat_ptr;
    logic       gath_ack;
    desc_t      gath_dat;
    frame_rpt_t frame;

    int          value_errors;
    int          other_errors;
    int          total_errors;
    int          cycle_count;
    int          scat_acks;
    logic [31:0] lcg_state;

    // Reference free list and expected memory contents
    ptr_t  free_q [$];
    desc_t exp_desc [NUM_BUFS];
    logic  held [NUM_BUFS];

    // Open frame as the model sees it
    logic                      model_open;
    ptr_t                      model_cur;
    ptr_t                      model_head;
    logic [FRAME_SIZE_WID-1:0] model_size;
    logic                      model_err;
    ptr_t                      frame_ptrs [$];

    // Pointer returned by the latest write
    ptr_t                      last_ptr;

    sg_alloc_top u_sg_alloc_top (
        .clk(clk), .rst_n(rst_n), .scat_cyc(scat_cyc), .scat_stb(scat_stb),
        .scat_dat(scat_dat), .gath_cyc(gath_cyc), .gath_stb(gath_stb),
        .gath_adr(gath_adr), .init_done(init_done), .scat_ack(scat_ack),
        .scat_ptr(scat_ptr), .gath_ack(gath_ack), .gath_dat(gath_dat), .frame(frame)
    );

    always #5 clk = ~clk;

    // Hang guard
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("Timeout: run hung waiting for an ack after %0d cycles", cycle_count);
            $display("Regression failed");
            $finish;
        end
    end

    // ==============================
    // Stimulus helpers
    // ==============================

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Upper LCG bits, low ones repeat too soon
    function automatic store_t make_store(input logic eof, input logic err);
        store_t      s;
        logic [31:0] r;
        r      = lcg_next();
        s.eof  = eof;
        s.size = r[21:16];
        s.meta = r[27:24];
        s.err  = err;
        return s;
    endfunction

    // One scatter cycle, stb held until ack seen
    task automatic scat_write(input store_t d, output ptr_t ptr, output frame_rpt_t rpt);
        scat_cyc = 1'b1;
        scat_stb = 1'b1;
        scat_dat = d;
        do begin
            @(negedge clk);
        end while (!scat_ack);
        ptr = scat_ptr;
        rpt = frame;
        scat_acks++;
        @(posedge clk);
        #1;
        scat_cyc = 1'b0;
        scat_stb = 1'b0;
    endtask

    task automatic gath_read(input ptr_t adr, output desc_t d);
        gath_cyc = 1'b1;
        gath_stb = 1'b1;
        gath_adr = adr;
        do begin
            @(negedge clk);
        end while (!gath_ack);
        d = gath_dat;
        @(posedge clk);
        #1;
        gath_cyc = 1'b0;
        gath_stb = 1'b0;
    endtask

    // ==============================
    // Compare tasks
    // ==============================

    task automatic check_ptr(input string name, input ptr_t exp, input ptr_t act);
        if (exp !== act) begin
            value_errors++;
            $display("[ERROR] %s: pointer expected %0d, actual %0d", name, exp, act);
        end
    endtask

    // Link field ignored on the last buffer
    task automatic check_desc(input string name, input desc_t exp, input desc_t act);
        desc_t e;
        e = exp;
        if (exp.eof) begin
            e.next_ptr = act.next_ptr;
        end
        if (e !== act) begin
            value_errors++;
            $display("[ERROR] %s: descriptor expected %h, actual %h", name, e, act);
        end
    endtask

    function automatic string format_frame(input frame_rpt_t f);
        return $sformatf("ptr=%0d size=%0d error=%0b valid=%0b",
                         f.ptr, f.size, f.error, f.valid);
    endfunction

    task automatic check_frame(input string name, input frame_rpt_t exp, input frame_rpt_t act);
        if (exp !== act) begin
            value_errors++;
            $display("[ERROR] %s: report expected %s, actual %s", name,
                     format_frame(exp), format_frame(act));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act) begin
            value_errors++;
            $display("[ERROR] %s: cycle count expected %0d, actual %0d", name, exp, act);
        end
    endtask

    // ==============================
    // Reference model
    // ==============================

    task automatic take_free(input string name, output ptr_t p);
        if (free_q.size() == 0) begin
            other_errors++;
            $display("%s: reference free list is empty, nothing to predict", name);
            p = '0;
        end else begin
            p = free_q.pop_front();
        end
    endtask

    // Store one buffer and check pointer and report against the linking rule
    task automatic store_buffer(input string name, input store_t d);
        ptr_t       ptr;
        ptr_t       nxt;
        frame_rpt_t rpt;
        frame_rpt_t exp_rpt;
        desc_t      ed;
        scat_write(d, ptr, rpt);
        last_ptr = ptr;
        if (!model_open) begin
            take_free(name, model_cur);
            model_head = model_cur;
            model_open = 1'b1;
            model_size = '0;
            model_err  = 1'b0;
            frame_ptrs.delete();
        end
        check_ptr(name, model_cur, ptr);
        frame_ptrs.push_back(model_cur);
        ed.next_ptr = '0;
        ed.eof      = d.eof;
        ed.size     = d.size;
        ed.meta     = d.meta;
        ed.err      = d.err;
        nxt         = '0;
        if (!d.eof) begin
            take_free(name, nxt);
            ed.next_ptr = nxt;
            if (rpt.valid) begin
                other_errors++;
                $display("%s: frame report raised on a buffer without eof", name);
            end
        end else begin
            exp_rpt.valid = 1'b1;
            exp_rpt.ptr   = model_head;
            exp_rpt.size  = model_size + d.size;
            exp_rpt.error = model_err | d.err;
            check_frame(name, exp_rpt, rpt);
            model_open = 1'b0;
        end
        exp_desc[model_cur] = ed;
        held[model_cur]     = 1'b1;
        if (!d.eof) begin
            model_size = model_size + BUFFER_SIZE;
            model_err  = model_err | d.err;
            model_cur  = nxt;
        end
    endtask

    // Read back one descriptor, pointer goes to the tail of the model list
    task automatic load_buffer(input string name, input ptr_t adr, output desc_t d);
        gath_read(adr, d);
        check_desc(name, exp_desc[adr], d);
        held[adr] = 1'b0;
        free_q.push_back(adr);
    endtask

    // err_idx below zero picks err at random
    task automatic store_frame(input string name, input int n, input int err_idx);
        logic e;
        for (int i = 0; i < n; i++) begin
            if (err_idx >= 0) begin
                e = (i == err_idx);
            end else begin
                e = (lcg_next() >> 28) == 0;
            end
            store_buffer(name, make_store(i == n - 1, e));
        end
    endtask

    // Follow next_ptr from the head
    task automatic walk_frame(input string name);
        ptr_t  p;
        desc_t d;
        p = frame_ptrs[0];
        for (int i = 0; i < frame_ptrs.size(); i++) begin
            check_ptr(name, frame_ptrs[i], p);
            load_buffer(name, p, d);
            p = d.next_ptr;
        end
    endtask

    // ==============================
    // Directed tests
    // ==============================

    task automatic test_reset();
        int n;
        // Requests on both ports while in reset
        scat_cyc = 1'b1;
        scat_stb = 1'b1;
        gath_cyc = 1'b1;
        gath_stb = 1'b1;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            if (scat_ack || gath_ack || frame.valid) begin
                other_errors++;
                $display("test_reset: ack or frame report seen during reset");
            end
        end
        @(posedge clk);
        #1;
        rst_n    = 1'b1;
        scat_cyc = 1'b0;
        scat_stb = 1'b0;
        n = 0;
        // Read request stays up across the fill
        while (!init_done && n < 4 * FILL_CYCLES) begin
            @(posedge clk);
            #1;
            n++;
            if (init_done) begin
                gath_cyc = 1'b0;
                gath_stb = 1'b0;
            end
            @(negedge clk);
            if (scat_ack || gath_ack || frame.valid) begin
                other_errors++;
                $display("test_reset: ack or frame report seen before init_done");
            end
        end
        if (!init_done) begin
            other_errors++;
            $display("test_reset: init_done never rose after reset");
        end else begin
            check_count("test_reset", FILL_CYCLES, n);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic test_single();
        desc_t d;
        store_buffer("test_single", make_store(1'b1, 1'b0));
        check_ptr("test_single", ptr_t'(0), last_ptr);
        load_buffer("test_single", ptr_t'(0), d);
    endtask

    task automatic test_multi();
        store_frame("test_multi", 5, -1);
        walk_frame("test_multi");
    endtask

    task automatic test_error();
        store_frame("test_error", 3, 1);
        walk_frame("test_error");
    endtask

    task automatic test_backpressure();
        desc_t d;
        int    acks_before;
        // First buffer takes two pointers, each later one takes one
        for (int i = 0; i < NUM_BUFS - 1; i++) begin
            store_buffer("test_backpressure", make_store(1'b0, 1'b0));
        end
        acks_before = scat_acks;
        fork
            store_buffer("test_backpressure", make_store(1'b0, 1'b0));
            begin
                repeat (6) @(posedge clk);
                #1;
                if (scat_acks != acks_before) begin
                    other_errors++;
                    $display("test_backpressure: write acked with no free pointer");
                end
                load_buffer("test_backpressure", model_head, d);
            end
        join
        store_buffer("test_backpressure", make_store(1'b1, 1'b0));
        // Hand every pointer back
        for (int i = 0; i < NUM_BUFS; i++) begin
            if (held[i]) begin
                load_buffer("test_backpressure", ptr_t'(i), d);
            end
        end
    endtask

    task automatic test_random();
        int n;
        for (int f = 0; f < 20; f++) begin
            n = (lcg_next() >> 29) + 1;
            store_frame("test_random", n, -1);
            walk_frame("test_random");
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        scat_cyc     = 1'b0;
        scat_stb     = 1'b0;
        scat_dat     = '0;
        gath_cyc     = 1'b0;
        gath_stb     = 1'b0;
        gath_adr     = '0;
        value_errors = 0;
        other_errors = 0;
        total_errors = 0;
        cycle_count  = 0;
        scat_acks    = 0;
        lcg_state    = 32'h0cfe6719;
        model_open   = 1'b0;
        last_ptr     = '0;
        for (int i = 0; i < NUM_BUFS; i++) begin
            free_q.push_back(ptr_t'(i));
            held[i] = 1'b0;
        end

        test_reset();
        test_single();
        test_multi();
        test_error();
        test_backpressure();
        test_random();

        // Let the bound checks see the last cycles
        repeat (2) @(posedge clk);
        total_errors = value_errors + other_errors
                     + u_sg_alloc_top.u_sg_alloc_assert.assert_errors;
        $display("Errors: %0d value, %0d other, %0d assertion", value_errors, other_errors,
                 u_sg_alloc_top.u_sg_alloc_assert.assert_errors);
        if (total_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
